// File: design/ili9341_pkg.sv
package ili9341_pkg;

    // One display word as it travels between stages
    typedef struct packed {
        logic       dc;     // 0 command, 1 data
        logic [7:0] data;
    } lcd_word_t;

    // --------------------
    // Panel opcodes
    typedef enum logic [7:0] {
        SWRESET   = 8'h01,
        SLPOUT    = 8'h11,
        GAMMASET  = 8'h26,
        DISPON    = 8'h29,
        CASET     = 8'h2A,  // Column address set
        PASET     = 8'h2B,  // Page address set
        RAMWR     = 8'h2C,
        MADCTL    = 8'h36,  // Memory access control
        VSCRADD   = 8'h37,
        PIXFMT    = 8'h3A,
        FRMCTR1   = 8'hB1,
        DFUNCTR   = 8'hB6,
        PWCTR1    = 8'hC0,
        PWCTR2    = 8'hC1,
        VMCTR1    = 8'hC5,
        VMCTR2    = 8'hC7,
        POWERA    = 8'hCB,
        POWERB    = 8'hCF,
        DTCA      = 8'hE8,
        DTCB      = 8'hEA,
        POWER_SEQ = 8'hED,
        GAMMA3_EN = 8'hF2,
        PRC       = 8'hF7   // Pump ratio control
    } lcd_cmd_e;

    typedef enum logic [3:0] {
        START,
        SEND_RESET,
        WAIT_RESET,
        SEND_INIT,
        WAIT_INIT,
        DISPLAY_ON,
        WAIT_ON,
        SET_ROTATION,
        SET_WINDOW,
        FRAME_LOOP,
        FRAME_PAUSE
    } seq_state_e;

    localparam int INIT_LEN = 51;
    localparam int WINDOW_WORDS = 11;              // CASET through RAMWR
    localparam logic [7:0] MADCTL_ROTATION = 8'hE8; // MY | MX | MV | BGR

    function automatic lcd_word_t cmd_word(input lcd_cmd_e cmd);
        return '{dc: 1'b0, data: cmd};
    endfunction

    function automatic lcd_word_t data_word(input logic [7:0] value);
        return '{dc: 1'b1, data: value};
    endfunction

    // --------------------
    // Power-up register table
    function automatic lcd_word_t init_word(input int unsigned idx);
        case (idx)
            0:  return cmd_word(POWERA);
            1:  return data_word(8'h39);
            2:  return data_word(8'h2C);
            3:  return data_word(8'h00);
            4:  return data_word(8'h34);
            5:  return data_word(8'h02);
            6:  return cmd_word(POWERB);
            7:  return data_word(8'h00);
            8:  return data_word(8'hC1);
            9:  return data_word(8'h30);
            10: return cmd_word(DTCA);
            11: return data_word(8'h85);
            12: return data_word(8'h00);
            13: return data_word(8'h78);
            14: return cmd_word(DTCB);
            15: return data_word(8'h00);
            16: return data_word(8'h00);
            17: return cmd_word(POWER_SEQ);
            18: return data_word(8'h64);
            19: return data_word(8'h03);
            20: return data_word(8'h12);
            21: return data_word(8'h81);
            22: return cmd_word(PRC);
            23: return data_word(8'h20);
            24: return cmd_word(PWCTR1);
            25: return data_word(8'h23);     // GVDD level
            26: return cmd_word(PWCTR2);
            27: return data_word(8'h10);
            28: return cmd_word(VMCTR1);
            29: return data_word(8'h3E);
            30: return data_word(8'h28);
            31: return cmd_word(VMCTR2);
            32: return data_word(8'h86);
            33: return cmd_word(MADCTL);
            34: return data_word(8'h48);     // Portrait until rotation is set
            35: return cmd_word(VSCRADD);
            36: return data_word(8'h00);
            37: return cmd_word(PIXFMT);
            38: return data_word(8'h55);     // 16 bits per pixel
            39: return cmd_word(FRMCTR1);
            40: return data_word(8'h00);
            41: return data_word(8'h18);
            42: return cmd_word(DFUNCTR);
            43: return data_word(8'h08);
            44: return data_word(8'h82);
            45: return data_word(8'h27);
            46: return cmd_word(GAMMA3_EN);
            47: return data_word(8'h00);
            48: return cmd_word(GAMMASET);
            49: return data_word(8'h01);
            50: return cmd_word(SLPOUT);
            default: return data_word(8'h00);
        endcase
    endfunction

endpackage

// File: design/spi_shifter.sv
module spi_shifter
    import ili9341_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  lcd_word_t tx_word,
    input  logic      tx_valid,
    output logic      tx_ready,
    output logic      spi_mosi,
    output logic      spi_sck,
    output logic      spi_cs,
    output logic      spi_dc
);

    logic       busy;
    logic [7:0] shift_q;
    logic [2:0] bit_cnt;
    logic       phase;   // 0 sck low half, 1 sck high half

    assign tx_ready = ~busy;
    assign spi_mosi = shift_q[7];   // MSB first

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            shift_q <= '0;
            bit_cnt <= '0;
            phase   <= 1'b0;
            spi_sck <= 1'b0;
            spi_cs  <= 1'b1;
            spi_dc  <= 1'b0;
        end else if (!busy) begin
            if (tx_valid) begin
                busy    <= 1'b1;
                shift_q <= tx_word.data;
                spi_dc  <= tx_word.dc;   // Held for the whole word
                spi_cs  <= 1'b0;
                bit_cnt <= '0;
                phase   <= 1'b0;
            end
        end else if (!phase) begin
            spi_sck <= 1'b1;   // Panel samples here
            phase   <= 1'b1;
        end else begin
            spi_sck <= 1'b0;
            phase   <= 1'b0;
            if (bit_cnt == 3'd7) begin
                // Last bit done, release the bus
                busy   <= 1'b0;
                spi_cs <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 3'd1;
                shift_q <= {shift_q[6:0], 1'b0};   // Next bit on falling sck
            end
        end
    end

endmodule

// File: design/pixel_splitter.sv
module pixel_splitter
    import ili9341_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] pixel_data,
    input  logic        pixel_valid,
    output logic        pixel_ready,
    output lcd_word_t   pix_word,
    output logic        pix_valid,
    input  logic        pix_ready
);

    logic [15:0] pixel_q;
    logic        full;
    logic        low_next;   // High byte already taken

    assign pixel_ready = ~full;
    assign pix_valid   = full;
    assign pix_word    = data_word(low_next ? pixel_q[7:0] : pixel_q[15:8]);

    always_ff @(posedge clk) begin
        if (pixel_valid && pixel_ready) begin
            pixel_q <= pixel_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full     <= 1'b0;
            low_next <= 1'b0;
        end else if (pixel_valid && pixel_ready) begin
            full     <= 1'b1;
            low_next <= 1'b0;
        end else if (pix_valid && pix_ready) begin
            if (low_next) begin
                full <= 1'b0;   // Both bytes gone
            end
            low_next <= ~low_next;
        end
    end

endmodule

// File: design/lcd_sequencer.sv
module lcd_sequencer
    import ili9341_pkg::*;
#(
    parameter int wait_cycles = 2_500_000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      frame_done,
    input  lcd_word_t pix_word,
    input  logic      pix_valid,
    output logic      pix_ready,
    output lcd_word_t tx_word,
    output logic      tx_valid,
    input  logic      tx_ready
);

    localparam int WAIT_W = $clog2(wait_cycles + 1);
    localparam int IDX_W = $clog2(INIT_LEN);
    localparam int STEP_W = $clog2(WINDOW_WORDS);

    seq_state_e        state_q;
    logic [IDX_W-1:0]  init_idx;
    logic [STEP_W-1:0] step;
    logic [WAIT_W-1:0] wait_cnt;
    logic              byte_odd;    // High byte of a pixel has been sent
    logic              wait_state;
    logic              wait_done;
    logic              pause_req;
    logic              tx_fire;

    assign tx_fire    = tx_valid && tx_ready;
    assign wait_state = (state_q == WAIT_RESET) || (state_q == WAIT_INIT) ||
                        (state_q == WAIT_ON);
    // Count only once the last word has left the pins
    assign wait_done  = wait_state && tx_ready && (wait_cnt == WAIT_W'(wait_cycles - 1));
    assign pause_req  = frame_done && !byte_odd;   // Only on a pixel boundary

    // --------------------
    // Word on offer
    always_comb begin
        tx_word   = data_word(8'h00);
        tx_valid  = 1'b0;
        pix_ready = 1'b0;
        case (state_q)
            SEND_RESET: begin
                tx_word  = cmd_word(SWRESET);
                tx_valid = 1'b1;
            end
            SEND_INIT: begin
                tx_word  = init_word(init_idx);
                tx_valid = 1'b1;
            end
            DISPLAY_ON: begin
                tx_word  = cmd_word(DISPON);
                tx_valid = 1'b1;
            end
            SET_ROTATION: begin
                tx_word  = (step == '0) ? cmd_word(MADCTL) : data_word(MADCTL_ROTATION);
                tx_valid = 1'b1;
            end
            SET_WINDOW: begin
                tx_valid = 1'b1;
                case (step)
                    STEP_W'(0):  tx_word = cmd_word(CASET);
                    STEP_W'(3):  tx_word = data_word(8'h01);
                    STEP_W'(4):  tx_word = data_word(8'h3F);   // Last column 319
                    STEP_W'(5):  tx_word = cmd_word(PASET);
                    STEP_W'(9):  tx_word = data_word(8'hEF);   // Last row 239
                    STEP_W'(10): tx_word = cmd_word(RAMWR);
                    default:     tx_word = data_word(8'h00);
                endcase
            end
            FRAME_LOOP: begin
                tx_word   = pix_word;
                tx_valid  = pix_valid && !pause_req;
                pix_ready = tx_ready && !pause_req;
            end
            default: ;
        endcase
    end

    // --------------------
    // Wait counter
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (wait_state && tx_ready) begin
            wait_cnt <= wait_done ? '0 : wait_cnt + 1'b1;
        end
    end

    // --------------------
    // Sequence FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= START;
            init_idx <= '0;
            step     <= '0;
            byte_odd <= 1'b0;
        end else begin
            case (state_q)
                START:      state_q <= SEND_RESET;
                SEND_RESET: if (tx_fire) state_q <= WAIT_RESET;
                WAIT_RESET: if (wait_done) state_q <= SEND_INIT;
                SEND_INIT: begin
                    if (tx_fire) begin
                        if (init_idx == IDX_W'(INIT_LEN - 1)) begin
                            init_idx <= '0;
                            state_q  <= WAIT_INIT;
                        end else begin
                            init_idx <= init_idx + 1'b1;
                        end
                    end
                end
                WAIT_INIT:  if (wait_done) state_q <= DISPLAY_ON;
                DISPLAY_ON: if (tx_fire) state_q <= WAIT_ON;
                WAIT_ON:    if (wait_done) state_q <= SET_ROTATION;
                SET_ROTATION: begin
                    if (tx_fire) begin
                        if (step == STEP_W'(1)) begin
                            step    <= '0;
                            state_q <= SET_WINDOW;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end
                SET_WINDOW: begin
                    if (tx_fire) begin
                        if (step == STEP_W'(WINDOW_WORDS - 1)) begin
                            step    <= '0;
                            state_q <= FRAME_LOOP;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                end
                FRAME_LOOP: begin
                    if (tx_fire) begin
                        byte_odd <= ~byte_odd;
                    end
                    if (pause_req) begin
                        state_q <= FRAME_PAUSE;
                    end
                end
                FRAME_PAUSE: if (!frame_done) state_q <= FRAME_LOOP;
                default:    state_q <= START;
            endcase
        end
    end

endmodule

// File: design/ili9341_controller.sv
module ili9341_controller
    import ili9341_pkg::*;
#(
    parameter int wait_cycles = 2_500_000   // 100 ms at 25 MHz
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] pixel_data,
    input  logic        pixel_valid,
    output logic        pixel_ready,
    input  logic        frame_done,
    output logic        spi_mosi,
    output logic        spi_sck,
    output logic        spi_cs,
    output logic        spi_dc
);

    lcd_word_t pix_word;
    logic      pix_valid;
    logic      pix_ready;
    lcd_word_t tx_word;
    logic      tx_valid;
    logic      tx_ready;

    // --------------------
    // Pixel bytes
    pixel_splitter u_splitter (
        .clk         (clk),
        .rst         (rst),
        .pixel_data  (pixel_data),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pix_word    (pix_word),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready)
    );

    lcd_sequencer #(
        .wait_cycles (wait_cycles)
    ) u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .frame_done (frame_done),
        .pix_word   (pix_word),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .tx_word    (tx_word),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready)
    );

    // SPI pins
    spi_shifter u_shifter (
        .clk      (clk),
        .rst      (rst),
        .tx_word  (tx_word),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .spi_mosi (spi_mosi),
        .spi_sck  (spi_sck),
        .spi_cs   (spi_cs),
        .spi_dc   (spi_dc)
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int period = 20,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;   // Released on a rising edge
    end

endmodule

// File: bench/ili9341_properties.sv
module ili9341_properties (
    input logic clk,
    input logic rst,
    input logic pixel_valid,
    input logic pixel_ready,
    input logic pix_valid,
    input logic pix_ready,
    input logic spi_cs,
    input logic spi_sck,
    input logic spi_dc
);

    int unsigned fail_count = 0;
    logic [1:0]  bytes_owed;   // Bytes of the held pixel not yet taken

    always_ff @(posedge clk) begin
        if (rst) begin
            bytes_owed <= 2'd0;
        end else if (pixel_valid && pixel_ready) begin
            bytes_owed <= 2'd2;
        end else if (pix_valid && pix_ready && bytes_owed != 2'd0) begin
            bytes_owed <= bytes_owed - 2'd1;
        end
    end

    // --------------------
    sck_idle_low: assert property (@(posedge clk) disable iff (rst) spi_cs |-> !spi_sck)
        else begin
            $error("sck high while chip select is inactive");
            fail_count++;
        end

    dc_steady: assert property (@(posedge clk) disable iff (rst)
        !spi_cs && $past(!spi_cs) |-> $stable(spi_dc))
        else begin
            $error("dc changed in the middle of a word");
            fail_count++;
        end

    // A held pixel blocks the next one until both bytes are gone
    pixel_held: assert property (@(posedge clk) disable iff (rst)
        bytes_owed != 2'd0 |-> !pixel_ready)
        else begin
            $error("pixel_ready high while a pixel is held");
            fail_count++;
        end

endmodule

// File: bench/ili9341_checker.sv
module ili9341_checker
    import ili9341_pkg::*;
#(
    parameter int wait_cycles = 50,
    parameter int pixel_count = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] pixel_data,
    input  logic        pixel_valid,
    input  logic        pixel_ready,
    input  logic        frame_done,
    input  logic        spi_mosi,
    input  logic        spi_sck,
    input  logic        spi_cs,
    input  logic        spi_dc,
    output logic        done,
    output int          passed,
    output int          failed
);

    localparam int SETUP_WORDS = INIT_LEN + 15;   // Reset, table, DISPON, MADCTL pair, window
    localparam int TOTAL_WORDS = SETUP_WORDS + 2 * pixel_count;

    logic [15:0] pixel_log[$];
    logic        cs_q = 1'b1;
    logic        sck_q = 1'b0;
    logic        fd_q = 1'b0;
    logic        in_reset = 1'b0;
    logic        reset_bad = 1'b0;
    logic        all_seen = 1'b0;
    logic        dc_cap;
    logic [7:0]  shreg;
    int          bit_cnt = 0;
    int          word_cnt = 0;
    int          idle_cnt = 0;
    int          pause_num = 0;
    int          pause_words = 0;
    int          pause_pixels = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    assign done   = all_seen;
    assign passed = pass_cnt;
    assign failed = fail_cnt;

    // --------------------
    // Reference word sequence
    function automatic logic [8:0] expected_word(input int n);
        int          k;
        logic [15:0] px;
        k = n - SETUP_WORDS;
        if (n == 0) return 9'h001;                  // SWRESET
        if (n <= INIT_LEN) return init_word(n - 1);
        if (n == INIT_LEN + 1) return 9'h029;       // DISPON
        if (n == INIT_LEN + 2) return 9'h036;       // MADCTL
        if (n == INIT_LEN + 3) return 9'h1E8;
        if (k < 0) begin
            case (n - INIT_LEN - 4)
                0:       return 9'h02A;             // CASET 0..319
                3:       return 9'h101;
                4:       return 9'h13F;
                5:       return 9'h02B;             // PASET 0..239
                9:       return 9'h1EF;
                10:      return 9'h02C;
                default: return 9'h100;
            endcase
        end
        px = pixel_log[k / 2];
        return (k % 2 == 0) ? {1'b1, px[15:8]} : {1'b1, px[7:0]};
    endfunction

    function automatic string test_name(input int n);
        if (n <= INIT_LEN + 1) return "power_up";
        if (n < SETUP_WORDS) return "window";
        return "pixel_stream";
    endfunction

    task automatic finish_word(input logic [8:0] actual);
        logic [8:0] expected;
        if (bit_cnt != 8) begin
            $display("Word %0d carried %0d bits instead of 8", word_cnt, bit_cnt);
            fail_cnt++;
        end else if (word_cnt >= SETUP_WORDS &&
                     (word_cnt - SETUP_WORDS) / 2 >= pixel_log.size()) begin
            $display("Pixel word %0d sent with no accepted pixel behind it", word_cnt);
            fail_cnt++;
        end else begin
            expected = expected_word(word_cnt);
            if (actual === expected) begin
                $display("%s word %0d PASS", test_name(word_cnt), word_cnt);
                pass_cnt++;
            end else begin
                $display("FAILED %s word %0d expected %03h actual %03h",
                         test_name(word_cnt), word_cnt, expected, actual);
                fail_cnt++;
            end
        end
        word_cnt++;
        if (word_cnt == TOTAL_WORDS) all_seen = 1'b1;
    endtask

    // --------------------
    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            in_reset = 1'b1;
            if (!spi_cs || spi_sck || spi_mosi || spi_dc || !pixel_ready) reset_bad = 1'b1;
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                if (reset_bad) begin
                    $display("SPI pins or pixel_ready left their idle level during reset");
                    fail_cnt++;
                end else begin
                    $display("reset_state PASS");
                    pass_cnt++;
                end
            end
            if (pixel_valid && pixel_ready) begin
                pixel_log.push_back(pixel_data);
                if (frame_done && fd_q) pause_pixels++;
            end
            if (cs_q && !spi_cs) begin
                dc_cap  = spi_dc;
                bit_cnt = 0;
                if (word_cnt == 1 || word_cnt == INIT_LEN + 1 || word_cnt == INIT_LEN + 2) begin
                    if (idle_cnt >= wait_cycles) begin
                        $display("wait_before_word %0d PASS", word_cnt);
                        pass_cnt++;
                    end else begin
                        $display("Chip select idle only %0d cycles before word %0d",
                                 idle_cnt, word_cnt);
                        fail_cnt++;
                    end
                end
                if (fd_q) begin
                    pause_words++;
                    if (word_cnt < SETUP_WORDS || (word_cnt - SETUP_WORDS) % 2 == 0)
                        pause_words += 2;   // Anything but a trailing low byte
                end
            end
            if (frame_done && !fd_q) begin
                pause_words  = 0;
                pause_pixels = 0;
            end
            if (!frame_done && fd_q) begin
                pause_num++;
                if (pause_words > 1 || pause_pixels > 1) begin
                    $display("Frame pause %0d let new pixel data through", pause_num);
                    fail_cnt++;
                end else begin
                    $display("frame_pause %0d PASS", pause_num);
                    pass_cnt++;
                end
            end
            if (!spi_cs && spi_sck && !sck_q) begin
                shreg = {shreg[6:0], spi_mosi};   // MSB first
                bit_cnt++;
            end
            if (!cs_q && spi_cs) finish_word({dc_cap, shreg});
            idle_cnt = spi_cs ? idle_cnt + 1 : 0;
        end
        cs_q  = spi_cs;
        sck_q = spi_sck;
        fd_q  = frame_done;
    end

endmodule

// File: bench/tb_ili9341.sv
module tb_ili9341;

    localparam int WAIT = 50;
    localparam int PIXELS = 64;
    localparam int PAUSE = 200;
    localparam int SETUP = 66;
    localparam int LIMIT = 2 * (3 * WAIT + SETUP * 18 + PIXELS * 36 + 2 * PAUSE);

    logic        clk;
    logic        rst;
    logic [15:0] pixel_data;
    logic        pixel_valid;
    logic        pixel_ready;
    logic        frame_done;
    logic        spi_mosi, spi_sck, spi_cs, spi_dc;
    logic        done;
    int          passed;
    int          failed;
    int          sent = 0;
    int          cycles = 0;

    tb_clock #(.period(20), .reset_cycles(5)) clock_gen (.clk, .rst);

    ili9341_controller #(.wait_cycles(WAIT)) uut (
        .clk, .rst, .pixel_data, .pixel_valid, .pixel_ready, .frame_done,
        .spi_mosi, .spi_sck, .spi_cs, .spi_dc
    );

    ili9341_checker #(.wait_cycles(WAIT), .pixel_count(PIXELS)) u_checker (
        .clk, .rst, .pixel_data, .pixel_valid, .pixel_ready, .frame_done,
        .spi_mosi, .spi_sck, .spi_cs, .spi_dc, .done, .passed, .failed
    );

    bind ili9341_controller ili9341_properties props (.*);

    task automatic hold_frame_done;
        @(posedge clk);
        frame_done <= 1'b1;
        repeat (PAUSE) @(posedge clk);
        frame_done <= 1'b0;
    endtask

    // --------------------
    // Pixel source with random gaps
    initial begin
        logic fire;
        pixel_data  = '0;
        pixel_valid = 1'b0;
        void'($urandom(32'h02726ddf));
        do @(negedge clk); while (rst);
        while (sent < PIXELS) begin
            @(negedge clk);
            fire = pixel_valid && pixel_ready;
            @(posedge clk);
            if (fire) sent++;
            if (!pixel_valid || fire) begin
                if (sent < PIXELS && $urandom_range(3) != 0) begin
                    pixel_data  <= 16'($urandom);
                    pixel_valid <= 1'b1;
                end else begin
                    pixel_valid <= 1'b0;
                end
            end
        end
    end

    initial begin
        frame_done = 1'b0;
        wait (sent >= 10);
        hold_frame_done();
        wait (sent >= 40);
        hold_frame_done();
    end

    // --------------------
    initial begin
        while (!done && cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("%0d checks passed, %0d checks failed, %0d assertion failures",
                 passed, failed, uut.props.fail_count);
        if (done && failed == 0 && uut.props.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            if (!done) $display("Timeout after %0d cycles, word stream incomplete", cycles);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: ili9341.f
design/ili9341_pkg.sv
design/spi_shifter.sv
design/pixel_splitter.sv
design/lcd_sequencer.sv
design/ili9341_controller.sv
bench/tb_clock.sv
bench/ili9341_properties.sv
bench/ili9341_checker.sv
bench/tb_ili9341.sv

// File: run.sh
#!/bin/sh
# Build and run the ILI9341 controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ili9341 \
    -f ili9341.f --Mdir obj_dir -o sim_ili9341
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_ili9341 +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
exit 1
